// ==== all.f ====
logic/read_engine_pkg.sv
logic/read_engine_if.sv
logic/read_config_decode.sv
logic/read_stream_control.sv
logic/mem_read_port.sv
logic/read_result_collect.sv
logic/read_engine_top.sv
tb/read_engine_tb.sv

// ==== Makefile ====
# Verilator build and run of the read engine testbench
TOP := read_engine_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f logic/*.sv tb/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@grep -q "Test passed" sim.log

lint:
	verilator --lint-only --timing --assert --top-module read_engine_top -f all.f
	verilator --lint-only --timing --assert --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir sim.log

// ==== tb/read_engine_tb.sv ====
`timescale 1ns/1ps
// Memory model returns the address XOR 32'h5a5a0000 after 0 to 3 wait cycles
// Expected data and transfer counts assume word-aligned job bases

module read_engine_tb;

	logic        clock        = 1'b0;
	logic        rstn         = 1'b0;
	logic        job_valid    = 1'b0;
	logic [31:0] job_base     = 32'd0;
	logic [15:0] job_count    = 16'd0;
	logic [31:0] job_config   = 32'd0;
	logic [31:0] wb_dat_i     = 32'd0;
	logic        wb_ack       = 1'b0;
	logic        out_ready    = 1'b0;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [31:0] wb_adr;
	logic        out_valid;
	logic [31:0] out_data;
	logic        job_busy;
	logic        job_done;
	logic [15:0] elements_done;

	integer      seed         = 32'he4171def;
	string       test_name    = "reset";
	logic        random_ready = 1'b0;
	logic        new_job      = 1'b0;

	read_engine_top u_dut (
		.clock         (clock),
		.rstn          (rstn),
		.job_valid     (job_valid),
		.job_base      (job_base),
		.job_count     (job_count),
		.job_config    (job_config),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_dat_i      (wb_dat_i),
		.wb_ack        (wb_ack),
		.out_valid     (out_valid),
		.out_data      (out_data),
		.out_ready     (out_ready),
		.job_busy      (job_busy),
		.job_done      (job_done),
		.elements_done (elements_done)
	);

	always #10 clock = ~clock;

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic expect_eq(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual == expected)
		else abort_run($sformatf("CHECK FAILED %s %s: expected %h, actual %h",
			test_name, what, expected, actual));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Wishbone memory and output sink
	//////////////////////////////////////////////////////////////////////

	logic [1:0] ack_wait = 2'd0;
	logic       in_xfer  = 1'b0;

	always @(posedge clock) begin : bus_and_sink
		logic [31:0] rnd;
		logic [1:0]  wait_now;
		rnd = $random(seed);
		// Throttled sink takes about three cycles in four
		out_ready <= random_ready ? (rnd[3:2] != 2'b00) : 1'b1;
		if (!rstn) begin
			wb_ack   <= 1'b0;
			in_xfer  <= 1'b0;
			ack_wait <= 2'd0;
		end else if (wb_ack) begin
			wb_ack  <= 1'b0;
			in_xfer <= 1'b0;
		end else if (wb_cyc && wb_stb) begin
			wait_now = in_xfer ? ack_wait : rnd[1:0];
			in_xfer <= 1'b1;
			if (wait_now == 2'd0) begin
				wb_ack   <= 1'b1;
				wb_dat_i <= wb_adr ^ 32'h5a5a_0000;
			end else begin
				ack_wait <= wait_now - 2'd1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Job tracking and protocol checks
	//////////////////////////////////////////////////////////////////////

	logic [31:0] cur_base     = 32'd0;
	logic [15:0] cur_count    = 16'd0;
	logic        cur_pf       = 1'b0;
	logic [15:0] out_seen     = 16'd0;
	logic [15:0] reads_seen   = 16'd0;
	logic [15:0] touches_seen = 16'd0;
	logic        xfer_wait_q  = 1'b0;
	logic        xfer_ack_q   = 1'b0;
	logic [31:0] xfer_adr     = 32'd0;
	logic        stall_q      = 1'b0;
	logic [31:0] stall_data   = 32'd0;
	logic        done_q       = 1'b0;

	always @(posedge clock) begin : job_monitor
		logic [31:0] next_read;
		next_read = cur_base + {14'd0, reads_seen, 2'b00};
		if (rstn) begin
			expect_eq("cyc and stb together", 32'(wb_cyc), 32'(wb_stb));
			expect_eq("wb_we", 32'd0, 32'(wb_we));
			if (xfer_wait_q) begin
				expect_eq("stb held until ack", 32'd1, 32'(wb_stb));
				expect_eq("wb_adr held", xfer_adr, wb_adr);
			end
			if (xfer_ack_q) begin
				expect_eq("cyc low after ack", 32'd0, 32'(wb_cyc));
			end
			if (stall_q) begin
				expect_eq("out_valid held", 32'd1, 32'(out_valid));
				expect_eq("out_data held", stall_data, out_data);
			end
			// Cycle after the done pulse
			if (done_q) begin
				expect_eq("job_done width", 32'd0, 32'(job_done));
				expect_eq("job_busy after job_done", 32'd0, 32'(job_busy));
			end
			if (new_job) begin
				cur_base     <= job_base;
				cur_count    <= job_count;
				cur_pf       <= job_config[0];
				out_seen     <= 16'd0;
				reads_seen   <= 16'd0;
				touches_seen <= 16'd0;
			end else begin
				if (wb_cyc && wb_stb && wb_ack) begin
					if (wb_adr == next_read) begin
						reads_seen <= reads_seen + 16'd1;
					end else if (cur_pf) begin
						expect_eq("touch page offset", 32'd0, {26'd0, wb_adr[5:0]});
						touches_seen <= touches_seen + 16'd1;
					end else begin
						expect_eq("read address", next_read, wb_adr);
					end
				end
				if (out_valid && out_ready) begin
					expect_eq("out_data",
						(cur_base + {14'd0, out_seen, 2'b00}) ^ 32'h5a5a_0000, out_data);
					out_seen <= out_seen + 16'd1;
				end
				if (job_done) begin
					expect_eq("elements_done", 32'(cur_count), 32'(elements_done));
					expect_eq("elements streamed", 32'(cur_count), 32'(out_seen));
					expect_eq("read transfers", 32'(cur_count), 32'(reads_seen));
					expect_eq("touch transfers",
						cur_pf ? 32'((cur_count + 16'd15) >> 4) : 32'd0, 32'(touches_seen));
					expect_eq("job_busy at job_done", 32'd1, 32'(job_busy));
				end
			end
		end
		xfer_wait_q <= wb_cyc && wb_stb && !wb_ack;
		xfer_ack_q  <= wb_cyc && wb_stb && wb_ack;
		xfer_adr    <= wb_adr;
		stall_q     <= out_valid && !out_ready;
		stall_data  <= out_data;
		done_q      <= job_done;
	end

	//////////////////////////////////////////////////////////////////////
	// Job stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic wait_idle();
		int waited;
		waited = 0;
		while (job_busy) begin
			@(posedge clock);
			waited++;
			if (waited > 200) begin
				abort_run("job_busy stayed high after the job ended");
			end
		end
	endtask

	task automatic run_job(input string name, input logic [31:0] base,
		input logic [15:0] count, input logic [31:0] cfg, input logic rnd, input logic poke);
		int waited;
		wait_idle();
		test_name = name;
		@(posedge clock);
		random_ready <= rnd;
		job_valid    <= 1'b1;
		new_job      <= 1'b1;
		job_base     <= base;
		job_count    <= count;
		job_config   <= cfg;
		@(posedge clock);
		job_valid <= 1'b0;
		new_job   <= 1'b0;
		// Second request while busy must be ignored
		if (poke) begin
			repeat (6) @(posedge clock);
			job_valid  <= 1'b1;
			job_base   <= base ^ 32'h0000_f000;
			job_count  <= count + 16'd3;
			job_config <= cfg ^ 32'h3f;
			@(posedge clock);
			job_valid <= 1'b0;
		end
		waited = 0;
		while (!job_done) begin
			@(posedge clock);
			waited++;
			if (waited > 20000) begin
				abort_run($sformatf("%s: job_done never came", name));
			end
		end
	endtask

	initial begin
		repeat (16) @(posedge clock);
		rstn <= 1'b1;
		@(posedge clock);
		expect_eq("wb_cyc after reset", 32'd0, 32'(wb_cyc));
		expect_eq("out_valid after reset", 32'd0, 32'(out_valid));
		expect_eq("job_busy after reset", 32'd0, 32'(job_busy));
		expect_eq("job_done after reset", 32'd0, 32'(job_done));
		expect_eq("elements_done after reset", 32'd0, 32'(elements_done));

		run_job("one_element", 32'h0000_1000, 16'd1, 32'h00, 1'b0, 1'b0);
		run_job("one_line", 32'h0000_2040, 16'd4, 32'h00, 1'b1, 1'b0);
		run_job("odd_count_prefetch", 32'h0000_3008, 16'd7, 32'h01, 1'b1, 1'b0);
		run_job("long_default", 32'h0000_4024, 16'd37, 32'h00, 1'b1, 1'b1);
		run_job("long_prefetch", 32'h0000_5004, 16'd37, 32'h01, 1'b1, 1'b1);
		// Window 16, then shift 15 up clamped to 16
		run_job("window_up", 32'h0000_6000, 16'd37, 32'h03, 1'b1, 1'b0);
		run_job("window_up_clamped", 32'h0000_7010, 16'd37, 32'h1e, 1'b0, 1'b0);
		// Window 2, then shift 5 down clamped to 1
		run_job("window_down", 32'h0000_8030, 16'd37, 32'h25, 1'b1, 1'b0);
		run_job("window_down_clamped", 32'h0000_9008, 16'd37, 32'h2b, 1'b1, 1'b1);
		run_job("window_min_plain", 32'h0000_a00c, 16'd7, 32'h2a, 1'b1, 1'b0);

		wait_idle();
		@(posedge clock);
		$display("Test passed");
		$finish;
	end

endmodule

// ==== logic/read_engine_top.sv ====
`timescale 1ns/1ps
// Read engine for one job at a time, job_valid is ignored while job_busy is high
// Memory side is a Wishbone classic read-only master

module read_engine_top (
	input  logic                                clock,
	input  logic                                rstn,
	input  logic                                job_valid,
	input  logic [read_engine_pkg::addr_w-1:0]  job_base,
	input  logic [read_engine_pkg::count_w-1:0] job_count,
	input  logic [31:0]                         job_config,
	output logic                                wb_cyc,
	output logic                                wb_stb,
	output logic                                wb_we,
	output logic [read_engine_pkg::addr_w-1:0]  wb_adr,
	input  logic [read_engine_pkg::data_w-1:0]  wb_dat_i,
	input  logic                                wb_ack,
	output logic                                out_valid,
	output logic [read_engine_pkg::data_w-1:0]  out_data,
	input  logic                                out_ready,
	output logic                                job_busy,
	output logic                                job_done,
	output logic [read_engine_pkg::count_w-1:0] elements_done
);
	import read_engine_pkg::*;

	logic                accept;
	logic                prefetch_en;
	logic [window_w-1:0] window;
	logic                resp_seen;
	logic                issue_done;

	read_cmd_if  cmd_bus ();
	read_resp_if resp_bus ();

	read_config_decode u_decode (
		.clock       (clock),
		.rstn        (rstn),
		.accept      (accept),
		.job_config  (job_config),
		.prefetch_en (prefetch_en),
		.window      (window)
	);

	read_stream_control u_control (
		.clock       (clock),
		.rstn        (rstn),
		.job_valid   (job_valid),
		.job_base    (job_base),
		.job_count   (job_count),
		.prefetch_en (prefetch_en),
		.window      (window),
		.resp_seen   (resp_seen),
		.cmd         (cmd_bus.issuer),
		.job_busy    (job_busy),
		.accept      (accept),
		.issue_done  (issue_done)
	);

	mem_read_port u_port (
		.clock     (clock),
		.rstn      (rstn),
		.cmd       (cmd_bus.server),
		.resp      (resp_bus.producer),
		.resp_seen (resp_seen),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_i  (wb_dat_i),
		.wb_ack    (wb_ack)
	);

	read_result_collect u_result (
		.clock         (clock),
		.rstn          (rstn),
		.resp          (resp_bus.consumer),
		.issue_done    (issue_done),
		.accept        (accept),
		.out_valid     (out_valid),
		.out_data      (out_data),
		.out_ready     (out_ready),
		.elements_done (elements_done),
		.job_done      (job_done)
	);

endmodule

// ==== logic/read_result_collect.sv ====
`timescale 1ns/1ps
// One-entry output register, a new response is taken only when it is empty
// Touch responses are consumed and dropped

module read_result_collect (
	input  logic                                clock,
	input  logic                                rstn,
	read_resp_if.consumer                       resp,
	input  logic                                issue_done,
	input  logic                                accept,
	output logic                                out_valid,
	output logic [read_engine_pkg::data_w-1:0]  out_data,
	input  logic                                out_ready,
	output logic [read_engine_pkg::count_w-1:0] elements_done,
	output logic                                job_done
);
	import read_engine_pkg::*;

	logic take;
	logic send;

	assign resp.ready = !out_valid;
	assign take       = resp.valid && resp.ready;
	assign send       = out_valid && out_ready;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			out_valid     <= 1'b0;
			elements_done <= '0;
			job_done      <= 1'b0;
		end else begin
			if (take && !resp.is_touch) begin
				out_valid <= 1'b1;
			end else if (send) begin
				out_valid <= 1'b0;
			end

			if (accept) begin
				elements_done <= '0;
			end else if (send) begin
				elements_done <= elements_done + count_w'(1);
			end

			// Issue side leaves its done phase on the same condition
			job_done <= issue_done && !out_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (take && !resp.is_touch) begin
			out_data <= resp.data;
		end
	end

	// A touch completes its command in one response
	assert property (@(posedge clock) disable iff (!rstn)
		take && resp.is_touch |-> resp.last_of_cmd);

endmodule

// ==== logic/mem_read_port.sv ====
`timescale 1ns/1ps
// Wishbone classic master, single transfers with no pipelining and no error handling
// Each result must be taken by the result stage before the next transfer starts

module mem_read_port (
	input  logic                               clock,
	input  logic                               rstn,
	read_cmd_if.server                         cmd,
	read_resp_if.producer                      resp,
	output logic                               resp_seen,
	output logic                               wb_cyc,
	output logic                               wb_stb,
	output logic                               wb_we,
	output logic [read_engine_pkg::addr_w-1:0] wb_adr,
	input  logic [read_engine_pkg::data_w-1:0] wb_dat_i,
	input  logic                               wb_ack
);
	import read_engine_pkg::*;

	logic              held;
	logic              cyc_q;
	logic              rv_q;
	logic              touch_q;
	logic [size_w-1:0] left_q;
	logic [addr_w-1:0] addr_q;
	logic [data_w-1:0] data_q;
	logic              take;
	logic              done;

	// New commands wait for the result stage as well
	assign cmd.ready = !held && resp.ready;
	assign take      = cmd.valid && cmd.ready;
	assign done      = resp.valid && resp.ready;

	assign wb_cyc = cyc_q;
	assign wb_stb = cyc_q;
	assign wb_we  = 1'b0;
	assign wb_adr = addr_q;

	assign resp.valid       = rv_q;
	assign resp.data        = data_q;
	assign resp.is_touch    = touch_q;
	assign resp.last_of_cmd = (left_q == size_w'(1));

	//////////////////////////////////////////////////////////////////////
	// Control: command held, bus cycle, response pending
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			held      <= 1'b0;
			cyc_q     <= 1'b0;
			rv_q      <= 1'b0;
			resp_seen <= 1'b0;
		end else begin
			resp_seen <= done && resp.last_of_cmd;
			if (take) begin
				held  <= 1'b1;
				cyc_q <= 1'b1;
			end else if (cyc_q && wb_ack) begin
				cyc_q <= 1'b0;
				rv_q  <= 1'b1;
			end else if (done) begin
				rv_q <= 1'b0;
				if (resp.last_of_cmd) begin
					held <= 1'b0;
				end else begin
					// Bus was idle at least while the response waited
					cyc_q <= 1'b1;
				end
			end
		end
	end

	// Address, remaining transfers and read data
	always_ff @(posedge clock) begin
		if (take) begin
			addr_q  <= cmd.address;
			left_q  <= cmd.is_touch ? size_w'(1) : cmd.real_size;
			touch_q <= cmd.is_touch;
		end else if (cyc_q && wb_ack) begin
			data_q <= touch_q ? '0 : wb_dat_i;
		end else if (done && !resp.last_of_cmd) begin
			addr_q <= addr_q + addr_w'(data_w / 8);
			left_q <= left_q - size_w'(1);
		end
	end

	assert property (@(posedge clock) disable iff (!rstn)
		wb_cyc && wb_stb && !wb_ack |=> wb_stb);

endmodule

// ==== logic/read_stream_control.sv ====
`timescale 1ns/1ps
// Touches are assumed to run ahead of the reads, which holds for any window
// A job ends only after the result stage has emptied its output register

module read_stream_control (
	input  logic                                 clock,
	input  logic                                 rstn,
	input  logic                                 job_valid,
	input  logic [read_engine_pkg::addr_w-1:0]   job_base,
	input  logic [read_engine_pkg::count_w-1:0]  job_count,
	input  logic                                 prefetch_en,
	input  logic [read_engine_pkg::window_w-1:0] window,
	input  logic                                 resp_seen,
	read_cmd_if.issuer                           cmd,
	output logic                                 job_busy,
	output logic                                 accept,
	output logic                                 issue_done
);
	import read_engine_pkg::*;

	stream_phase_t       phase;
	logic [count_w-1:0]  read_left;
	logic [count_w-1:0]  touch_left;
	logic [addr_w-1:0]   read_addr;
	logic [addr_w-1:0]   touch_addr;
	logic [window_w-1:0] sent;
	logic [window_w-1:0] seen;
	logic [count_w-1:0]  read_step;
	logic [count_w-1:0]  touch_step;
	logic                fire;
	logic                batch_full;
	logic                clear_batch;

	assign accept      = job_valid && !job_busy;
	assign fire        = cmd.valid && cmd.ready;
	assign read_step   = (read_left > count_w'(line_elems)) ? count_w'(line_elems) : read_left;
	assign touch_step  = (touch_left > count_w'(page_elems)) ? count_w'(page_elems) : touch_left;
	assign batch_full  = (sent + window_w'(1)) == window;
	assign clear_batch = (phase == set) || (phase == prefetch_start) || (phase == read_start);
	assign issue_done  = (phase == batch_done) && (read_left == '0) && (touch_left == '0);

	//////////////////////////////////////////////////////////////////////
	// Command fields come straight from the counters
	//////////////////////////////////////////////////////////////////////

	assign cmd.valid = ((phase == prefetch_req) && (touch_left != '0)) ||
		((phase == read_req) && (read_left != '0));
	assign cmd.is_touch  = (phase == prefetch_req);
	assign cmd.address   = cmd.is_touch ? touch_addr : read_addr;
	assign cmd.real_size = cmd.is_touch ? size_w'(1) : read_step[size_w-1:0];

	//////////////////////////////////////////////////////////////////////
	// Batch FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			phase      <= idle;
			job_busy   <= 1'b0;
			read_left  <= '0;
			touch_left <= '0;
			read_addr  <= '0;
			touch_addr <= '0;
			sent       <= '0;
			seen       <= '0;
		end else begin
			// Busy drops one cycle after the FSM returns to idle
			job_busy <= accept || (job_busy && phase != idle);

			if (clear_batch) begin
				sent <= '0;
				seen <= '0;
			end else begin
				sent <= sent + window_w'(fire);
				seen <= seen + window_w'(resp_seen);
			end

			if (fire) begin
				if (cmd.is_touch) begin
					touch_left <= touch_left - touch_step;
					touch_addr <= touch_addr + addr_w'(page_bytes);
				end else begin
					read_left <= read_left - read_step;
					read_addr <= read_addr + addr_w'(line_bytes);
				end
			end

			case (phase)
				idle: begin
					if (accept) begin
						phase      <= set;
						read_left  <= job_count;
						touch_left <= job_count;
						read_addr  <= job_base;
						touch_addr <= job_base & ~addr_w'(page_bytes - 1);
					end
				end
				// First batch skips the start phase
				set: begin
					if (prefetch_en) begin
						phase <= prefetch_req;
					end else begin
						touch_left <= '0;
						phase      <= read_req;
					end
				end
				prefetch_start: phase <= prefetch_req;
				prefetch_req: begin
					if (touch_left == '0 ||
						(fire && (batch_full || touch_left == touch_step))) begin
						phase <= prefetch_pending;
					end
				end
				prefetch_pending: begin
					if (sent == seen) begin
						phase <= read_start;
					end
				end
				read_start: phase <= read_req;
				read_req: begin
					if (read_left == '0 || (fire && (batch_full || read_left == read_step))) begin
						phase <= read_pending;
					end
				end
				read_pending: begin
					if (sent == seen) begin
						phase <= batch_done;
					end
				end
				batch_done: begin
					// Port ready here also means the output register is empty
					if (issue_done) begin
						if (cmd.ready) begin
							phase <= idle;
						end
					end else if (prefetch_en && touch_left != '0) begin
						phase <= prefetch_start;
					end else begin
						phase <= read_start;
					end
				end
				default: phase <= idle;
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (!rstn)
		fire |-> (cmd.is_touch ? touch_left != '0 : read_left != '0));

	// Completions come back from the memory port
	assert property (@(posedge clock) disable iff (!rstn)
		(sent - seen) <= window);

endmodule

// ==== logic/read_config_decode.sv ====
`timescale 1ns/1ps
// Only bits 5:0 of the configuration word are decoded
// Outputs hold their value until the next accepted job

module read_config_decode (
	input  logic                                 clock,
	input  logic                                 rstn,
	input  logic                                 accept,
	input  logic [31:0]                          job_config,
	output logic                                 prefetch_en,
	output logic [read_engine_pkg::window_w-1:0] window
);
	import read_engine_pkg::*;

	logic [cfg_shift_msb-cfg_shift_lsb:0] shift_amt;
	logic [31:0]                          shifted;
	logic [window_w-1:0]                  clamped;

	// Scale the default window, then clamp it
	always_comb begin
		shift_amt = job_config[cfg_shift_msb:cfg_shift_lsb];
		if (job_config[cfg_shift_down_bit]) begin
			shifted = 32'(base_window) >> shift_amt;
		end else begin
			shifted = 32'(base_window) << shift_amt;
		end
		if (shifted < 32'(min_window)) begin
			clamped = window_w'(min_window);
		end else if (shifted > 32'(max_window)) begin
			clamped = window_w'(max_window);
		end else begin
			clamped = shifted[window_w-1:0];
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			prefetch_en <= 1'b0;
			window      <= window_w'(base_window);
		end else if (accept) begin
			prefetch_en <= job_config[cfg_prefetch_bit];
			window      <= clamped;
		end
	end

	// Execute stage sizes its batches with this
	assert property (@(posedge clock) disable iff (!rstn)
		window >= window_w'(min_window) && window <= window_w'(max_window));

endmodule

// ==== logic/read_engine_if.sv ====
`timescale 1ns/1ps
// Stage-to-stage handshakes, a transfer happens when valid and ready are both high
// The sender holds valid and every field steady until that cycle

// Line and touch commands, execute stage to memory port
interface read_cmd_if;
	import read_engine_pkg::*;

	logic              valid;
	logic              ready;
	logic [addr_w-1:0] address;
	logic [size_w-1:0] real_size;
	logic              is_touch;

	modport issuer (
		output valid, address, real_size, is_touch,
		input  ready
	);

	modport server (
		input  valid, address, real_size, is_touch,
		output ready
	);
endinterface

// One entry per bus transfer, memory port to result stage
interface read_resp_if;
	import read_engine_pkg::*;

	logic              valid;
	logic              ready;
	logic [data_w-1:0] data;
	logic              is_touch;
	logic              last_of_cmd;

	modport producer (
		output valid, data, is_touch, last_of_cmd,
		input  ready
	);

	modport consumer (
		input  valid, data, is_touch, last_of_cmd,
		output ready
	);
endinterface

// ==== logic/read_engine_pkg.sv ====
// Sizes, config field positions and FSM phases shared by the read engine
// Elements are 32-bit words, and a job is limited to 2^16-1 elements

package read_engine_pkg;

	//////////////////////////////////////////////////////////////////////
	// Bus and counter widths
	//////////////////////////////////////////////////////////////////////

	localparam int addr_w   = 32;
	localparam int data_w   = 32;
	localparam int count_w  = 16;
	localparam int window_w = 5;

	// Elements per command fit in 0..4
	localparam int size_w = 3;

	//////////////////////////////////////////////////////////////////////
	// Line and page geometry
	//////////////////////////////////////////////////////////////////////

	localparam int line_elems = 4;
	localparam int line_bytes = 16;
	localparam int page_elems = 16;
	localparam int page_bytes = 64;

	// Batch window, counted in commands
	localparam int base_window = 8;
	localparam int max_window  = 16;
	localparam int min_window  = 1;

	//////////////////////////////////////////////////////////////////////
	// Configuration word fields
	//////////////////////////////////////////////////////////////////////

	localparam int cfg_prefetch_bit   = 0;
	localparam int cfg_shift_lsb      = 1;
	localparam int cfg_shift_msb      = 4;
	localparam int cfg_shift_down_bit = 5;

	// Batch sequencing phases of the execute stage
	typedef enum logic [3:0] {
		idle,
		set,
		prefetch_start,
		prefetch_req,
		prefetch_pending,
		read_start,
		read_req,
		read_pending,
		batch_done
	} stream_phase_t;

endpackage
